//--- Bender.yml
package:
  name: cipher_ctrl

sources:
  - hw/cipher_ctrl_pkg.sv
  - hw/sp2v_check.sv
  - hw/cipher_ctrl_rail.sv
  - hw/rail_combine.sv
  - hw/cipher_ctrl_top.sv
  - target: test
    files:
      - test/tb_cipher_ctrl.sv

//--- flist.f
hw/cipher_ctrl_pkg.sv
hw/sp2v_check.sv
hw/cipher_ctrl_rail.sv
hw/rail_combine.sv
hw/cipher_ctrl_top.sv
test/tb_cipher_ctrl.sv

//--- hw/cipher_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Cipher round controller definitions
////////////////////////////////////////////////////////////

package cipher_ctrl_pkg;

  // Bits per sparse signal and number of controller rails
  parameter int unsigned Sp2VWidth = 2;

  parameter int unsigned NumHsSig = 3;  // Sparse handshake inputs

  // Sparse two-valued code
  // Codes 00 and 11 flag a fault
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 2'b01,
    SP2V_LOW  = 2'b10
  } sp2v_e;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  typedef enum logic [1:0] {
    AES_128 = 2'b00,
    AES_192 = 2'b01,
    AES_256 = 2'b10
  } key_len_e;

  typedef logic [3:0] rnd_ctr_t;

  parameter rnd_ctr_t MaxRndCtr = 4'd13;  // Last round of AES_256

  // State register source
  typedef enum logic [2:0] {
    STATE_INIT  = 3'b001,  // Input block
    STATE_ROUND = 3'b010,  // Round output
    STATE_CLEAR = 3'b100   // Idle
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  typedef struct packed {
    state_sel_e  state_sel;
    add_rk_sel_e add_rk_sel;
  } ctrl_sel_t;

  typedef struct packed {
    sp2v_e in_valid;
    sp2v_e out_ready;
    sp2v_e sbox_out_req;
  } hs_sp_t;

  // One rail's bit of each sparse input
  typedef struct packed {
    logic in_valid;
    logic out_ready;
    logic sbox_out_req;
  } rail_hs_t;

  typedef struct packed {
    logic      in_ready;   // Rail polarity
    logic      out_valid;  // Rail polarity
    logic      state_we;   // Rail polarity
    logic      sbox_en;    // Rail polarity
    logic      sbox_ack;   // Rail polarity
    ctrl_sel_t ctrl_sel;
    rnd_ctr_t  rnd_ctr;
    logic      alert;
  } rail_out_t;

  // Rounds per block for a key length
  function automatic rnd_ctr_t num_rounds(key_len_e key_len);
    rnd_ctr_t n;
    case (key_len)
      AES_192: n = 4'd12;
      AES_256: n = 4'd14;
      default: n = 4'd10;
    endcase
    return n;
  endfunction

endpackage

//--- hw/cipher_ctrl_rail.sv
////////////////////////////////////////////////////////////
// Cipher controller rail
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cipher_ctrl_rail import cipher_ctrl_pkg::*; #(
  parameter bit Polarity      = 1'b1,
  parameter bit CiphOpFwdOnly = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rail_hs_t  hs_i,
  input  ciph_op_e  op_i,
  input  key_len_e  key_len_i,
  input  logic      enc_err_i,
  input  logic      mismatch_err_i,
  output ciph_op_e  op_o,
  output rail_out_t rail_o
);

  typedef enum logic [2:0] {
    IDLE,
    INIT,
    ROUND,
    OUT,
    ERROR
  } rail_state_e;

  localparam logic Inv = ~Polarity;  // Active-low rail

  rail_state_e state_d, state_q;
  rnd_ctr_t    rnd_ctr_d, rnd_ctr_q;
  rnd_ctr_t    rnd_last;
  ciph_op_e    op_q;
  key_len_e    key_len_q;
  rail_hs_t    hs;
  logic        err;
  logic        last_rnd;
  logic        cfg_we;
  logic        in_valid;
  logic        out_ready;
  logic        sbox_req;
  logic        in_ready;
  logic        out_valid;
  logic        state_we;
  logic        sbox_en;
  logic        sbox_ack;
  ctrl_sel_t   ctrl_sel;

  // Convert to active-high view
  assign hs  = rail_hs_t'(hs_i ^ {$bits(rail_hs_t){Inv}});
  assign err = enc_err_i | mismatch_err_i;

  // No handshake is honoured on a corrupted code
  assign in_valid  = hs.in_valid & ~enc_err_i;
  assign out_ready = hs.out_ready & ~enc_err_i;
  assign sbox_req  = hs.sbox_out_req & ~enc_err_i;

  assign rnd_last = num_rounds(key_len_q) - rnd_ctr_t'(1);
  assign last_rnd = (rnd_ctr_q == rnd_last);

  ////////////////////////////////////////////////////////////
  // Round FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    cfg_we    = 1'b0;
    in_ready  = 1'b0;
    out_valid = 1'b0;
    state_we  = 1'b0;
    sbox_en   = 1'b0;
    sbox_ack  = 1'b0;
    ctrl_sel  = '{state_sel: STATE_CLEAR, add_rk_sel: ADD_RK_INIT};

    case (state_q)
      IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          cfg_we  = 1'b1;  // Sample op and key length
          state_d = INIT;
        end
      end

      INIT: begin
        state_we  = 1'b1;  // Load input block
        ctrl_sel  = '{state_sel: STATE_INIT, add_rk_sel: ADD_RK_INIT};
        rnd_ctr_d = '0;
        state_d   = ROUND;
      end

      ROUND: begin
        ctrl_sel.state_sel  = STATE_ROUND;
        ctrl_sel.add_rk_sel = last_rnd ? ADD_RK_FINAL : ADD_RK_ROUND;
        sbox_en             = ~sbox_req;
        if (sbox_req) begin
          sbox_ack = 1'b1;
          state_we = 1'b1;
          if (last_rnd) begin
            state_d = OUT;
          end else begin
            rnd_ctr_d = rnd_ctr_q + rnd_ctr_t'(1);
          end
        end
      end

      OUT: begin
        out_valid = 1'b1;
        if (out_ready) begin
          state_d = IDLE;
        end
      end

      default: state_d = ERROR;  // ERROR is terminal
    endcase

    if (err) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      rnd_ctr_q <= '0;
      op_q      <= CIPH_FWD;
      key_len_q <= AES_128;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      if (cfg_we) begin
        op_q      <= CiphOpFwdOnly ? CIPH_FWD : op_i;
        key_len_q <= key_len_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign op_o = op_q;

  assign rail_o.in_ready  = in_ready ^ Inv;
  assign rail_o.out_valid = out_valid ^ Inv;
  assign rail_o.state_we  = state_we ^ Inv;
  assign rail_o.sbox_en   = sbox_en ^ Inv;
  assign rail_o.sbox_ack  = sbox_ack ^ Inv;
  assign rail_o.ctrl_sel  = ctrl_sel;
  assign rail_o.rnd_ctr   = rnd_ctr_q;
  assign rail_o.alert     = (state_q == ERROR);

  // Counter stays within the longest key schedule
  a_rnd_ctr_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
      rnd_ctr_q <= MaxRndCtr);

endmodule

//--- hw/cipher_ctrl_top.sv
////////////////////////////////////////////////////////////
// Cipher round controller top
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cipher_ctrl_top import cipher_ctrl_pkg::*; #(
  parameter bit CiphOpFwdOnly = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Start handshake
  input  sp2v_e     in_valid_i,
  output sp2v_e     in_ready_o,

  // Result handshake
  output sp2v_e     out_valid_o,
  input  sp2v_e     out_ready_i,

  input  ciph_op_e  op_i,
  input  key_len_e  key_len_i,

  // S-box exchange with the data path
  output sp2v_e     sbox_en_o,
  input  sp2v_e     sbox_out_req_i,
  output sp2v_e     sbox_ack_o,

  output sp2v_e     state_we_o,
  output ctrl_sel_t ctrl_sel_o,

  // Key expansion
  output ciph_op_e  key_expand_op_o,
  output rnd_ctr_t  key_round_o,

  output logic      alert_o
);

  // Rail polarity follows the bits of the HIGH code
  localparam logic [Sp2VWidth-1:0] HighBits = SP2V_HIGH;

  hs_sp_t                    hs_sp;
  rail_hs_t  [Sp2VWidth-1:0] rail_hs;
  rail_out_t [Sp2VWidth-1:0] rail_out;
  ciph_op_e  [Sp2VWidth-1:0] rail_op;
  logic                      enc_err;
  logic                      mismatch_err;

  assign hs_sp.in_valid     = in_valid_i;
  assign hs_sp.out_ready    = out_ready_i;
  assign hs_sp.sbox_out_req = sbox_out_req_i;

  sp2v_check u_sp2v_check (
    .hs_i      ( hs_sp   ),
    .rail_hs_o ( rail_hs ),
    .enc_err_o ( enc_err )
  );

  ////////////////////////////////////////////////////////////
  // Redundant rails
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_rail
    cipher_ctrl_rail #(
      .Polarity      ( HighBits[i]   ),
      .CiphOpFwdOnly ( CiphOpFwdOnly )
    ) u_rail (
      .clk_i          ( clk_i        ),
      .rst_ni         ( rst_ni       ),
      .hs_i           ( rail_hs[i]   ),
      .op_i           ( op_i         ),
      .key_len_i      ( key_len_i    ),
      .enc_err_i      ( enc_err      ),
      .mismatch_err_i ( mismatch_err ),  // Shared by both rails
      .op_o           ( rail_op[i]   ),
      .rail_o         ( rail_out[i]  )
    );
  end

  rail_combine u_rail_combine (
    .rails_i         ( rail_out        ),
    .op_i            ( rail_op         ),
    .in_ready_o      ( in_ready_o      ),
    .out_valid_o     ( out_valid_o     ),
    .state_we_o      ( state_we_o      ),
    .sbox_en_o       ( sbox_en_o       ),
    .sbox_ack_o      ( sbox_ack_o      ),
    .ctrl_sel_o      ( ctrl_sel_o      ),
    .key_round_o     ( key_round_o     ),
    .key_expand_op_o ( key_expand_op_o ),
    .alert_o         ( alert_o         ),
    .mismatch_err_o  ( mismatch_err    )
  );

endmodule

//--- hw/rail_combine.sv
////////////////////////////////////////////////////////////
// Rail output merge and mismatch check
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rail_combine import cipher_ctrl_pkg::*; (
  input  rail_out_t [Sp2VWidth-1:0] rails_i,
  input  ciph_op_e  [Sp2VWidth-1:0] op_i,
  output sp2v_e                     in_ready_o,
  output sp2v_e                     out_valid_o,
  output sp2v_e                     state_we_o,
  output sp2v_e                     sbox_en_o,
  output sp2v_e                     sbox_ack_o,
  output ctrl_sel_t                 ctrl_sel_o,
  output rnd_ctr_t                  key_round_o,
  output ciph_op_e                  key_expand_op_o,
  output logic                      alert_o,
  output logic                      mismatch_err_o
);

  logic [Sp2VWidth-1:0] sp_in_ready;
  logic [Sp2VWidth-1:0] sp_out_valid;
  logic [Sp2VWidth-1:0] sp_state_we;
  logic [Sp2VWidth-1:0] sp_sbox_en;
  logic [Sp2VWidth-1:0] sp_sbox_ack;
  logic [Sp2VWidth-1:0] mr_alert;

  ////////////////////////////////////////////////////////////
  // Sparse outputs
  ////////////////////////////////////////////////////////////

  // Each rail drives its own bit of the code
  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_bits
    assign sp_in_ready[i]  = rails_i[i].in_ready;
    assign sp_out_valid[i] = rails_i[i].out_valid;
    assign sp_state_we[i]  = rails_i[i].state_we;
    assign sp_sbox_en[i]   = rails_i[i].sbox_en;
    assign sp_sbox_ack[i]  = rails_i[i].sbox_ack;
    assign mr_alert[i]     = rails_i[i].alert;
  end

  assign in_ready_o  = sp2v_e'(sp_in_ready);
  assign out_valid_o = sp2v_e'(sp_out_valid);
  assign state_we_o  = sp2v_e'(sp_state_we);
  assign sbox_en_o   = sp2v_e'(sp_sbox_en);
  assign sbox_ack_o  = sp2v_e'(sp_sbox_ack);

  assign alert_o = |mr_alert;  // One rail is enough

  ////////////////////////////////////////////////////////////
  // Merge and compare
  ////////////////////////////////////////////////////////////

  // Differing rails either break the one-hot code or show up below
  always_comb begin
    ctrl_sel_o      = '0;
    key_round_o     = '0;
    key_expand_op_o = CIPH_FWD;
    mismatch_err_o  = 1'b0;

    for (int i = 0; i < Sp2VWidth; i++) begin
      ctrl_sel_o      = ctrl_sel_t'(ctrl_sel_o | rails_i[i].ctrl_sel);
      key_round_o     = key_round_o | rails_i[i].rnd_ctr;
      key_expand_op_o = ciph_op_e'(key_expand_op_o | op_i[i]);
    end

    for (int i = 0; i < Sp2VWidth; i++) begin
      if (ctrl_sel_o      != rails_i[i].ctrl_sel ||
          key_round_o     != rails_i[i].rnd_ctr  ||
          key_expand_op_o != op_i[i]) begin
        mismatch_err_o = 1'b1;
      end
    end
  end

  // A state write always has one source and one round key choice
  a_sel_onehot : assert final (
      state_we_o != SP2V_HIGH ||
      ($onehot(ctrl_sel_o.state_sel) && $onehot(ctrl_sel_o.add_rk_sel)))
    else $error("rail_combine: selector not one-hot on state write");

endmodule

//--- hw/sp2v_check.sv
////////////////////////////////////////////////////////////
// Sparse handshake check and rail split
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sp2v_check import cipher_ctrl_pkg::*; (
  input  hs_sp_t                   hs_i,
  output rail_hs_t [Sp2VWidth-1:0] rail_hs_o,
  output logic                     enc_err_o
);

  logic [NumHsSig-1:0][Sp2VWidth-1:0] sig;
  logic [NumHsSig-1:0]                sig_err;

  assign sig = hs_i;

  ////////////////////////////////////////////////////////////
  // Encoding check
  ////////////////////////////////////////////////////////////

  // Legal codes always have two differing bits
  for (genvar j = 0; j < NumHsSig; j++) begin : gen_chk
    assign sig_err[j] = ~^sig[j];
  end

  assign enc_err_o = |sig_err;

  ////////////////////////////////////////////////////////////
  // Rail split
  ////////////////////////////////////////////////////////////

  // Rail i takes bit i of every field
  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_split
    assign rail_hs_o[i].in_valid     = hs_i.in_valid[i];
    assign rail_hs_o[i].out_ready    = hs_i.out_ready[i];
    assign rail_hs_o[i].sbox_out_req = hs_i.sbox_out_req[i];
  end

  // Every code outside HIGH and LOW must be flagged
  a_enc_err : assert final (
      $isunknown(hs_i) ||
      (hs_i.in_valid     inside {SP2V_HIGH, SP2V_LOW} &&
       hs_i.out_ready    inside {SP2V_HIGH, SP2V_LOW} &&
       hs_i.sbox_out_req inside {SP2V_HIGH, SP2V_LOW}) ||
      enc_err_o)
    else $error("sp2v_check: invalid code without enc_err_o");

endmodule

//--- test/tb_cipher_ctrl.sv
////////////////////////////////////////////////////////////
// Cipher round controller testbench
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_cipher_ctrl import cipher_ctrl_pkg::*; ();

  localparam int ClkPeriod  = 100;
  localparam int DriveDelay = 10;  // Inputs change after the rising edge

  // Rounds over all blocks: 128, 256, 192 and the back-pressure block
  localparam int TotalRounds    = 10 + 14 + 12 + 10;
  localparam int WatchdogCycles = 20 * TotalRounds + 200;

  logic      clk_i;
  logic      rst_ni;
  sp2v_e     in_valid, in_ready, out_valid, out_ready;
  sp2v_e     sbox_en, sbox_req, sbox_ack, state_we;
  ciph_op_e  op, key_expand_op;
  key_len_e  key_len;
  ctrl_sel_t ctrl_sel;
  rnd_ctr_t  key_round;
  logic      alert;
  integer    seed;
  int        errors;

  cipher_ctrl_top #(
    .CiphOpFwdOnly ( 1'b0 )
  ) u_dut (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .in_valid_i      ( in_valid      ),
    .in_ready_o      ( in_ready      ),
    .out_valid_o     ( out_valid     ),
    .out_ready_i     ( out_ready     ),
    .op_i            ( op            ),
    .key_len_i       ( key_len       ),
    .sbox_en_o       ( sbox_en       ),
    .sbox_out_req_i  ( sbox_req      ),
    .sbox_ack_o      ( sbox_ack      ),
    .state_we_o      ( state_we      ),
    .ctrl_sel_o      ( ctrl_sel      ),
    .key_expand_op_o ( key_expand_op ),
    .key_round_o     ( key_round     ),
    .alert_o         ( alert         )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_sp2v(input sp2v_e act, input sp2v_e exp, input string what);
    if (act !== exp) stop_on_error($sformatf("%s is %b, expected %b", what, act, exp));
  endtask

  task automatic check_sel(input ctrl_sel_t act, input ctrl_sel_t exp, input string what);
    if (act !== exp) stop_on_error($sformatf("%s is %b, expected %b", what, act, exp));
  endtask

  task automatic check_ctr(input rnd_ctr_t act, input rnd_ctr_t exp, input string what);
    if (act !== exp) stop_on_error($sformatf("%s is %0d, expected %0d", what, act, exp));
  endtask

  task automatic check_op(input ciph_op_e act, input ciph_op_e exp, input string what);
    if (act !== exp) stop_on_error($sformatf("%s is %b, expected %b", what, act, exp));
  endtask

  task automatic check_alert(input logic act, input logic exp, input string what);
    if (act !== exp) stop_on_error($sformatf("%s is %b, expected %b", what, act, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #(DriveDelay);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset();
    @(negedge clk_i);
    check_sp2v(in_ready, SP2V_HIGH, "in_ready_o after reset");
    check_sp2v(out_valid, SP2V_LOW, "out_valid_o after reset");
    check_sp2v(sbox_en, SP2V_LOW, "sbox_en_o after reset");
    check_sp2v(sbox_ack, SP2V_LOW, "sbox_ack_o after reset");
    check_sp2v(state_we, SP2V_LOW, "state_we_o after reset");
    check_alert(alert, 1'b0, "alert_o after reset");
  endtask

  // One block with the data path model answering each S-box request
  task automatic run_block(input ciph_op_e blk_op, input key_len_e blk_len,
                           input int n_rounds);
    int          count;
    int          delay;
    add_rk_sel_e rk_exp;
    ctrl_sel_t   sel_exp;
    count = 0;
    next_cycle();
    op       = blk_op;
    key_len  = blk_len;
    in_valid = SP2V_HIGH;
    @(negedge clk_i);
    check_sp2v(in_ready, SP2V_HIGH, "in_ready_o before start");
    next_cycle();
    in_valid = SP2V_LOW;
    op       = (blk_op == CIPH_FWD) ? CIPH_INV : CIPH_FWD;  // Must not be sampled again
    key_len  = (blk_len == AES_128) ? AES_256 : AES_128;
    @(negedge clk_i);
    sel_exp = '{state_sel: STATE_INIT, add_rk_sel: ADD_RK_INIT};
    check_sp2v(state_we, SP2V_HIGH, "state_we_o on INIT write");
    check_sel(ctrl_sel, sel_exp, "ctrl_sel_o on INIT write");
    check_op(key_expand_op, blk_op, "key_expand_op_o");
    next_cycle();
    @(negedge clk_i);
    while (out_valid != SP2V_HIGH) begin
      if (count >= n_rounds) stop_on_error("more S-box exchanges than rounds");
      check_sp2v(sbox_en, SP2V_HIGH, "sbox_en_o while waiting");
      check_sp2v(sbox_ack, SP2V_LOW, "sbox_ack_o while waiting");
      check_sp2v(state_we, SP2V_LOW, "state_we_o while waiting");
      check_ctr(key_round, rnd_ctr_t'(count), "key_round_o while waiting");
      delay = $unsigned($random(seed)) % 4;  // Extra data path cycles
      repeat (delay) begin
        next_cycle();
        @(negedge clk_i);
        check_sp2v(sbox_en, SP2V_HIGH, "sbox_en_o while waiting");
        check_sp2v(sbox_ack, SP2V_LOW, "sbox_ack_o while waiting");
        check_sp2v(state_we, SP2V_LOW, "state_we_o while waiting");
      end
      next_cycle();
      sbox_req = SP2V_HIGH;
      @(negedge clk_i);
      rk_exp  = (count == n_rounds - 1) ? ADD_RK_FINAL : ADD_RK_ROUND;
      sel_exp = '{state_sel: STATE_ROUND, add_rk_sel: rk_exp};
      check_sp2v(sbox_ack, SP2V_HIGH, "sbox_ack_o on exchange");
      check_sp2v(state_we, SP2V_HIGH, "state_we_o on exchange");
      check_sp2v(sbox_en, SP2V_LOW, "sbox_en_o on exchange");
      check_sel(ctrl_sel, sel_exp, "ctrl_sel_o on exchange");
      check_ctr(key_round, rnd_ctr_t'(count), "key_round_o on exchange");
      check_op(key_expand_op, blk_op, "key_expand_op_o");
      count++;
      next_cycle();
      sbox_req = SP2V_LOW;
      @(negedge clk_i);
    end
    if (count != n_rounds) begin
      stop_on_error($sformatf("%0d S-box exchanges, expected %0d", count, n_rounds));
    end
    check_sp2v(in_ready, SP2V_LOW, "in_ready_o with result pending");
  endtask

  // Hold out_ready LOW for a number of cycles, then take the result
  task automatic release_result(input int hold);
    repeat (hold) begin
      next_cycle();
      @(negedge clk_i);
      check_sp2v(out_valid, SP2V_HIGH, "out_valid_o under back-pressure");
      check_sp2v(in_ready, SP2V_LOW, "in_ready_o under back-pressure");
    end
    next_cycle();
    out_ready = SP2V_HIGH;
    @(negedge clk_i);
    check_sp2v(out_valid, SP2V_HIGH, "out_valid_o on result transfer");
    next_cycle();
    out_ready = SP2V_LOW;
    @(negedge clk_i);
    check_sp2v(in_ready, SP2V_HIGH, "in_ready_o after result transfer");
    check_sp2v(out_valid, SP2V_LOW, "out_valid_o after result transfer");
  endtask

  task automatic invalid_code_test();
    next_cycle();
    in_valid = sp2v_e'(2'b11);
    @(negedge clk_i);
    check_alert(alert, 1'b0, "alert_o before the edge");
    next_cycle();
    check_alert(alert, 1'b1, "alert_o after invalid code");
    in_valid  = SP2V_HIGH;  // Valid code back again
    out_ready = SP2V_HIGH;
    repeat (4) begin
      @(negedge clk_i);
      check_alert(alert, 1'b1, "alert_o in ERROR");
      check_sp2v(out_valid, SP2V_LOW, "out_valid_o in ERROR");
      check_sp2v(in_ready, SP2V_LOW, "in_ready_o in ERROR");
      next_cycle();
    end
    in_valid  = SP2V_LOW;
    out_ready = SP2V_LOW;
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    seed      = 32'he91f5480;
    errors    = 0;
    rst_ni    = 1'b0;
    in_valid  = SP2V_LOW;
    out_ready = SP2V_LOW;
    sbox_req  = SP2V_LOW;
    op        = CIPH_FWD;
    key_len   = AES_128;
    repeat (2) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;

    check_reset();
    run_block(CIPH_INV, AES_128, 10);
    release_result(0);
    run_block(CIPH_FWD, AES_256, 14);
    release_result(0);
    run_block(CIPH_INV, AES_192, 12);
    release_result(0);
    run_block(CIPH_FWD, AES_128, 10);
    release_result(5);
    invalid_code_test();

    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: tests did not finish within %0d cycles", WatchdogCycles);
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule
